//--- all.f
+incdir+design
+incdir+verif
design/hyper_rx_pkg.sv
design/rwds_clk_gate.sv
design/cdc_fifo_gray.sv
design/hyper_read_path.sv
design/hyper_rx_regs.sv
design/hyper_rx_top.sv
verif/hyper_rx_props.sv
verif/hyper_rx_tb.sv

//--- design/cdc_fifo_gray.sv
// Dual-clock FIFO with gray-coded pointers, generic over its payload type

`default_nettype none

module cdc_fifo_gray #(
    parameter type         T         = logic,
    parameter int unsigned LOG_DEPTH = 4
) (
    // Write side
    input  logic src_rst_ni,
    input  logic src_clk_i,
    input  T     src_data_i,
    input  logic src_valid_i,
    output logic src_ready_o,

    // Read side
    input  logic dst_rst_ni,
    input  logic dst_clk_i,
    output T     dst_data_o,
    output logic dst_valid_o,
    input  logic dst_ready_i
);

    localparam int unsigned DEPTH = 2 ** LOG_DEPTH;
    // One extra bit tells a full FIFO from an empty one
    localparam int unsigned PTR_W = LOG_DEPTH + 1;
    // Full in gray code: top two bits inverted, the rest equal
    localparam logic [PTR_W-1:0] FULL_MASK = PTR_W'(3) << (PTR_W - 2);

    // Storage, written in the source domain only
    T mem_q [DEPTH];

    // Write pointer, source domain
    logic [PTR_W-1:0] wr_bin_q;
    logic [PTR_W-1:0] wr_bin_d;
    logic [PTR_W-1:0] wr_gray_q;
    logic [PTR_W-1:0] wr_gray_d;

    // Read pointer, destination domain
    logic [PTR_W-1:0] rd_bin_q;
    logic [PTR_W-1:0] rd_bin_d;
    logic [PTR_W-1:0] rd_gray_q;
    logic [PTR_W-1:0] rd_gray_d;

    // Read pointer seen by the source domain
    logic [PTR_W-1:0] rd_gray_sync1_q;
    logic [PTR_W-1:0] rd_gray_sync2_q;

    // Write pointer seen by the destination domain
    logic [PTR_W-1:0] wr_gray_sync1_q;
    logic [PTR_W-1:0] wr_gray_sync2_q;

    logic src_push;
    logic dst_pop;

    function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Source domain
    // Full when the write pointer is one lap ahead of the synced read pointer
    assign src_ready_o = (wr_gray_q != (rd_gray_sync2_q ^ FULL_MASK));
    assign src_push    = src_valid_i & src_ready_o;
    assign wr_bin_d    = wr_bin_q + PTR_W'(src_push);
    assign wr_gray_d   = bin2gray(wr_bin_d);

    always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
        if (!src_rst_ni) begin
            wr_bin_q        <= '0;
            wr_gray_q       <= '0;
            rd_gray_sync1_q <= '0;
            rd_gray_sync2_q <= '0;
        end else begin
            wr_bin_q        <= wr_bin_d;
            wr_gray_q       <= wr_gray_d;
            rd_gray_sync1_q <= rd_gray_q;
            rd_gray_sync2_q <= rd_gray_sync1_q;
        end
    end

    always_ff @(posedge src_clk_i) begin
        if (src_push) begin
            mem_q[wr_bin_q[LOG_DEPTH-1:0]] <= src_data_i;
        end
    end

    // Destination domain
    // Empty when the synced write pointer equals the read pointer
    assign dst_valid_o = (rd_gray_q != wr_gray_sync2_q);
    assign dst_pop     = dst_valid_o & dst_ready_i;
    assign rd_bin_d    = rd_bin_q + PTR_W'(dst_pop);
    assign rd_gray_d   = bin2gray(rd_bin_d);

    // Head of the FIFO, read without a register
    assign dst_data_o = mem_q[rd_bin_q[LOG_DEPTH-1:0]];

    always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
        if (!dst_rst_ni) begin
            rd_bin_q        <= '0;
            rd_gray_q       <= '0;
            wr_gray_sync1_q <= '0;
            wr_gray_sync2_q <= '0;
        end else begin
            rd_bin_q        <= rd_bin_d;
            rd_gray_q       <= rd_gray_d;
            wr_gray_sync1_q <= wr_gray_q;
            wr_gray_sync2_q <= wr_gray_sync1_q;
        end
    end

endmodule

`default_nettype wire

//--- design/hyper_read_path.sv
// HyperBus read data path: DDR capture on clk_rwds and crossing of words into clk_sys_i

`default_nettype none

`include "hyper_rx_params.svh"

module hyper_read_path (
    input  logic                      clk_sys_i,
    input  logic                      rst_ni,
    input  logic                      hyper_rwds_i,
    input  logic [7:0]                hyper_dq_i,
    input  logic                      read_en_i,
    input  logic                      rx_ready_i,
    output hyper_rx_pkg::hyper_word_t rx_data_o,
    output logic                      rx_valid_o,
    output logic                      drop_pulse_o
);

    // Gated strobe and its inverse, the FIFO write clock
    logic clk_rwds;
    logic clk_rwds_n;

    // Held low outside a burst, flushes the FIFO in both domains
    logic burst_rst_n;

    // FIFO write strobe
    logic wr_valid_q;
    logic fifo_ready;

    // First byte of the word, from the rising edge
    logic [7:0] upper_q;
    hyper_rx_pkg::hyper_word_t wr_word;

    // Lost-word toggle and its resync into clk_sys_i
    logic       drop_toggle_q;
    logic [2:0] drop_sync_q;

    // Strobe reaches the capture flops only while reads are enabled
    rwds_clk_gate i_rwds_clk_gate (
        .clk_i  ( hyper_rwds_i ),
        .en_i   ( read_en_i    ),
        .rst_ni ( rst_ni       ),
        .clk_o  ( clk_rwds     )
    );

    assign clk_rwds_n  = ~clk_rwds;
    assign burst_rst_n = rst_ni & read_en_i;

    // Set by the first rising edge of a burst
    // Dropping read_en clears it without a strobe edge
    always_ff @(posedge clk_rwds or negedge burst_rst_n) begin
        if (!burst_rst_n) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= 1'b1;
        end
    end

    // Rising edge: upper byte
    always_ff @(posedge clk_rwds) begin
        upper_q <= hyper_dq_i;
    end

    // Falling edge: upper byte plus the DQ byte now on the bus
    assign wr_word = {upper_q, hyper_dq_i};

    // Written on the falling RWDS edge
    // Last word lands although the strobe stops right after it
    cdc_fifo_gray #(
        .T         ( hyper_rx_pkg::hyper_word_t ),
        .LOG_DEPTH ( `HYPER_RX_LOG_DEPTH        )
    ) i_cdc_fifo_gray (
        .src_rst_ni  ( burst_rst_n ),
        .src_clk_i   ( clk_rwds_n  ),
        .src_data_i  ( wr_word     ),
        .src_valid_i ( wr_valid_q  ),
        .src_ready_o ( fifo_ready  ),
        .dst_rst_ni  ( burst_rst_n ),
        .dst_clk_i   ( clk_sys_i   ),
        .dst_data_o  ( rx_data_o   ),
        .dst_valid_o ( rx_valid_o  ),
        .dst_ready_i ( rx_ready_i  )
    );

    // Word offered to a full FIFO is lost, flip the toggle
    // Only the system reset clears it, so a flush makes no false edge
    always_ff @(posedge clk_rwds_n or negedge rst_ni) begin
        if (!rst_ni) begin
            drop_toggle_q <= 1'b0;
        end else if (wr_valid_q && !fifo_ready) begin
            drop_toggle_q <= ~drop_toggle_q;
        end
    end

    // Two sync stages, then one more flop for edge detection
    always_ff @(posedge clk_sys_i or negedge rst_ni) begin
        if (!rst_ni) begin
            drop_sync_q <= '0;
        end else begin
            drop_sync_q <= {drop_sync_q[1:0], drop_toggle_q};
        end
    end

    assign drop_pulse_o = drop_sync_q[2] ^ drop_sync_q[1];

endmodule

`default_nettype wire

//--- design/hyper_rx_params.svh
// Shared widths and FIFO depth of the HyperBus receive path, included by RTL and testbench

`ifndef HYPER_RX_PARAMS_SVH
`define HYPER_RX_PARAMS_SVH

// Log2 of the read FIFO depth
// 4 gives 16 words of buffering between clk_rwds and clk_sys_i
`define HYPER_RX_LOG_DEPTH 4

// Width of one received word, two DQ bytes
`define HYPER_RX_WORD_W 16

// Width of the register address on the configuration bus
// Four registers: CTRL, BURST_LEN, STATUS, COUNT
`define HYPER_RX_ADDR_W 2

`endif

//--- design/hyper_rx_pkg.sv
// Types shared by the receive path RTL and its testbench, referenced by scoped name

`default_nettype none

`include "hyper_rx_params.svh"

package hyper_rx_pkg;

    // One read word
    // First byte on DQ lands in the upper half
    typedef logic [`HYPER_RX_WORD_W-1:0] hyper_word_t;

    // Register map of the configuration bus
    typedef enum logic [`HYPER_RX_ADDR_W-1:0] {
        // Bit 0 arms or aborts a burst
        CTRL      = 2'd0,
        // Number of words in the burst
        BURST_LEN = 2'd1,
        // Busy, sticky overflow, sticky done
        STATUS    = 2'd2,
        // Words delivered in the current burst
        COUNT     = 2'd3
    } reg_addr_e;

endpackage

`default_nettype wire

//--- design/hyper_rx_regs.sv
// Configuration and status registers that arm read bursts and track delivered words

`default_nettype none

`include "hyper_rx_params.svh"

module hyper_rx_regs (
    input  logic                        clk_sys_i,
    input  logic                        rst_ni,
    input  logic                        cfg_we_i,
    input  hyper_rx_pkg::reg_addr_e     cfg_addr_i,
    input  logic [`HYPER_RX_WORD_W-1:0] cfg_wdata_i,
    output logic [`HYPER_RX_WORD_W-1:0] cfg_rdata_o,
    input  logic                        rx_valid_i,
    input  logic                        rx_ready_i,
    input  logic                        drop_pulse_i,
    output logic                        read_en_o
);

    localparam int unsigned W = `HYPER_RX_WORD_W;

    // Enable doubles as busy
    logic         enable_q;
    logic [W-1:0] burst_len_q;
    logic [W-1:0] count_q;
    logic         overflow_q;
    logic         done_q;

    // Word accepted by the consumer inside an armed burst
    logic xfer;
    logic last_xfer;

    // Counting stops at BURST_LEN, so COUNT cannot pass it
    assign xfer      = enable_q & rx_valid_i & rx_ready_i & (count_q != burst_len_q);
    assign last_xfer = xfer & ((count_q + W'(1)) == burst_len_q);

    always_ff @(posedge clk_sys_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q    <= 1'b0;
            burst_len_q <= '0;
            count_q     <= '0;
            overflow_q  <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            if (xfer) begin
                count_q <= count_q + W'(1);
            end
            // Burst ends by itself at the last word
            if (last_xfer) begin
                enable_q <= 1'b0;
                done_q   <= 1'b1;
            end
            if (drop_pulse_i) begin
                overflow_q <= 1'b1;
            end
            // Bus writes take priority over the events above
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    hyper_rx_pkg::CTRL: begin
                        // Set arms a fresh burst, clear aborts
                        enable_q <= cfg_wdata_i[0];
                        if (cfg_wdata_i[0]) begin
                            count_q    <= '0;
                            overflow_q <= 1'b0;
                            done_q     <= 1'b0;
                        end
                    end
                    hyper_rx_pkg::BURST_LEN: begin
                        burst_len_q <= cfg_wdata_i;
                    end
                    hyper_rx_pkg::STATUS: begin
                        // Write 1 to clear
                        if (cfg_wdata_i[1]) begin
                            overflow_q <= 1'b0;
                        end
                        if (cfg_wdata_i[2]) begin
                            done_q <= 1'b0;
                        end
                    end
                    default: begin
                        // COUNT is read-only
                    end
                endcase
            end
        end
    end

    // Read mux, combinational from the address
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            hyper_rx_pkg::CTRL:      cfg_rdata_o[0] = enable_q;
            hyper_rx_pkg::BURST_LEN: cfg_rdata_o = burst_len_q;
            hyper_rx_pkg::STATUS:    cfg_rdata_o[2:0] = {done_q, overflow_q, enable_q};
            default:                 cfg_rdata_o = count_q;
        endcase
    end

    assign read_en_o = enable_q;

endmodule

`default_nettype wire

//--- design/hyper_rx_top.sv
// Top of the HyperBus receive path: register block beside the read data path

`default_nettype none

`include "hyper_rx_params.svh"

module hyper_rx_top (
    input  logic                        clk_sys_i,
    input  logic                        rst_ni,

    // Memory pins
    input  logic                        hyper_rwds_i,
    input  logic [7:0]                  hyper_dq_i,

    // Configuration bus
    input  logic                        cfg_we_i,
    input  hyper_rx_pkg::reg_addr_e     cfg_addr_i,
    input  logic [`HYPER_RX_WORD_W-1:0] cfg_wdata_i,
    output logic [`HYPER_RX_WORD_W-1:0] cfg_rdata_o,

    // Word stream
    output hyper_rx_pkg::hyper_word_t   rx_data_o,
    output logic                        rx_valid_o,
    input  logic                        rx_ready_i
);

    // Burst armed, gates the strobe
    logic read_en;
    // One cycle per word lost to a full FIFO
    logic drop_pulse;

    // Counts transfers on the outgoing stream
    hyper_rx_regs i_hyper_rx_regs (
        .clk_sys_i    ( clk_sys_i   ),
        .rst_ni       ( rst_ni      ),
        .cfg_we_i     ( cfg_we_i    ),
        .cfg_addr_i   ( cfg_addr_i  ),
        .cfg_wdata_i  ( cfg_wdata_i ),
        .cfg_rdata_o  ( cfg_rdata_o ),
        .rx_valid_i   ( rx_valid_o  ),
        .rx_ready_i   ( rx_ready_i  ),
        .drop_pulse_i ( drop_pulse  ),
        .read_en_o    ( read_en     )
    );

    hyper_read_path i_hyper_read_path (
        .clk_sys_i    ( clk_sys_i    ),
        .rst_ni       ( rst_ni       ),
        .hyper_rwds_i ( hyper_rwds_i ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .read_en_i    ( read_en      ),
        .rx_ready_i   ( rx_ready_i   ),
        .rx_data_o    ( rx_data_o    ),
        .rx_valid_o   ( rx_valid_o   ),
        .drop_pulse_o ( drop_pulse   )
    );

endmodule

`default_nettype wire

//--- design/rwds_clk_gate.sv
// Glitch-free latch clock gate that turns the RWDS strobe into clk_rwds during reads

`default_nettype none

module rwds_clk_gate (
    input  logic clk_i,
    input  logic en_i,
    input  logic rst_ni,
    output logic clk_o
);

    // Enable as seen through the low phase of the strobe
    logic en_latched;

    // Transparent while the strobe is low
    // Enable changes only reach the AND gate outside the high phase
    always_latch begin
        if (!rst_ni) begin
            // Gate closed, output held low
            en_latched <= 1'b0;
        end else if (!clk_i) begin
            en_latched <= en_i;
        end
    end

    // Gated strobe
    assign clk_o = clk_i & en_latched;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module hyper_rx_tb -o hyper_rx_sim \
    || exit 1
out="$(./obj_dir/hyper_rx_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed!" && exit 0 || exit 1

//--- verif/hyper_rx_props.sv
// Bound checks on the receive word stream and register flags, attached to the receive top

`default_nettype none

`include "hyper_rx_params.svh"

module hyper_rx_props (
    input logic                        clk_sys_i,
    input logic                        rst_ni,
    input logic                        read_en_i,
    input logic                        rx_valid_i,
    input logic                        rx_ready_i,
    input logic [`HYPER_RX_WORD_W-1:0] rx_data_i,
    input logic                        busy_i,
    input logic                        done_i,
    input logic [`HYPER_RX_WORD_W-1:0] count_i,
    input logic [`HYPER_RX_WORD_W-1:0] burst_len_i
);

    // Offered word holds until taken
    // An abort flushes the FIFO, so a dropped enable releases the check
    stream_hold: assert property (@(posedge clk_sys_i) disable iff (!rst_ni)
        rx_valid_i && !rx_ready_i |=> !read_en_i || (rx_valid_i && $stable(rx_data_i)))
        else $error("rx_valid_o fell or rx_data_o changed before a transfer");

    // Arming clears done, finishing clears busy
    flags_exclusive: assert property (@(posedge clk_sys_i) disable iff (!rst_ni)
        !(busy_i && done_i))
        else $error("busy and done are both set");

    // Counting stops at the programmed length
    count_bound: assert property (@(posedge clk_sys_i) disable iff (!rst_ni)
        busy_i |-> count_i <= burst_len_i)
        else $error("COUNT is above BURST_LEN during a burst");

endmodule

bind hyper_rx_top hyper_rx_props i_hyper_rx_props (
    .clk_sys_i   ( clk_sys_i                   ),
    .rst_ni      ( rst_ni                      ),
    .read_en_i   ( read_en                     ),
    .rx_valid_i  ( rx_valid_o                  ),
    .rx_ready_i  ( rx_ready_i                  ),
    .rx_data_i   ( rx_data_o                   ),
    .busy_i      ( i_hyper_rx_regs.enable_q    ),
    .done_i      ( i_hyper_rx_regs.done_q      ),
    .count_i     ( i_hyper_rx_regs.count_q     ),
    .burst_len_i ( i_hyper_rx_regs.burst_len_q )
);

`default_nettype wire

//--- verif/hyper_rx_tests.svh
// Burst driver, stream consumer and directed tests that are included into the testbench module

// Draws the burst words up front with the first DQ byte as the upper byte
task automatic prepare_words(input int n);
    hyper_rx_pkg::hyper_word_t w;
    int k;
    for (k = 0; k < n; k++) begin
        w[15:8] = rand_byte();
        w[7:0] = rand_byte();
        exp_q.push_back(w);
        send_q.push_back(w);
    end
endtask

// One RWDS period per word with DQ centred on both edges
task automatic drive_burst();
    hyper_rx_pkg::hyper_word_t w;
    @(negedge clk_sys_i);
    while (send_q.size() != 0) begin
        w = send_q.pop_front();
        hyper_dq_i = w[15:8];
        #RWDS_QUARTER hyper_rwds_i = 1'b1;
        #RWDS_QUARTER hyper_dq_i = w[7:0];
        #RWDS_QUARTER hyper_rwds_i = 1'b0;
        #RWDS_QUARTER;
    end
endtask

// Ready is set on the falling edge and the transfer follows at the next rising edge
task automatic collect_words(input int n, input logic random_ready);
    hyper_rx_pkg::hyper_word_t exp_w;
    logic take;
    int got;
    int cycles;
    got = 0;
    cycles = 0;
    while (got < n && cycles < WORD_TIMEOUT) begin
        @(negedge clk_sys_i);
        take = random_ready ? rand_bit() : 1'b1;
        rx_ready_i = take;
        if (rx_valid_o && take) begin
            exp_w = exp_q.pop_front();
            check_value("received word", rx_data_o, exp_w);
            got++;
        end
        cycles++;
    end
    if (got < n) begin
        note_timeout("stream words");
    end
endtask

task automatic wait_status(input logic [15:0] mask, input logic [15:0] value,
                           input string what);
    logic [15:0] st;
    int cycles;
    cycles = 0;
    read_reg(hyper_rx_pkg::STATUS, st);
    while ((st & mask) != value && cycles < STATUS_TIMEOUT) begin
        read_reg(hyper_rx_pkg::STATUS, st);
        cycles++;
    end
    if ((st & mask) != value) begin
        note_timeout(what);
    end
endtask

// Stream must stay empty
task automatic expect_idle(input int n);
    int k;
    for (k = 0; k < n; k++) begin
        @(negedge clk_sys_i);
        assert (!rx_valid_o) else begin
            $display("Error at time %0t: rx_valid_o high after the last stored word", $time);
            err_count++;
        end
    end
endtask

// Sends an armed burst and waits for it to finish
task automatic stream_burst(input int n, input logic random_ready);
    prepare_words(n);
    fork
        drive_burst();
        collect_words(n, random_ready);
    join
    wait_status(16'h0001, 16'h0000, "busy to clear");
endtask

task automatic run_burst(input int n, input logic random_ready);
    write_reg(hyper_rx_pkg::BURST_LEN, 16'(n));
    write_reg(hyper_rx_pkg::CTRL, 16'h0001);
    stream_burst(n, random_ready);
endtask

task automatic access_registers();
    logic [15:0] rd;
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT after reset", rd, 16'h0000);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after reset", rd, 16'h0000);
    read_reg(hyper_rx_pkg::CTRL, rd);
    check_value("CTRL after reset", rd, 16'h0000);
    write_reg(hyper_rx_pkg::BURST_LEN, 16'hA5C3);
    read_reg(hyper_rx_pkg::BURST_LEN, rd);
    check_value("BURST_LEN", rd, 16'hA5C3);
    write_reg(hyper_rx_pkg::BURST_LEN, 16'h0005);
    read_reg(hyper_rx_pkg::BURST_LEN, rd);
    check_value("BURST_LEN", rd, 16'h0005);
    // Arm with no strobe and abort again
    write_reg(hyper_rx_pkg::CTRL, 16'h0001);
    read_reg(hyper_rx_pkg::CTRL, rd);
    check_value("CTRL armed", rd, 16'h0001);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS armed", rd, 16'h0001);
    write_reg(hyper_rx_pkg::CTRL, 16'h0000);
    read_reg(hyper_rx_pkg::CTRL, rd);
    check_value("CTRL aborted", rd, 16'h0000);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS aborted", rd, 16'h0000);
endtask

task automatic run_basic_burst();
    logic [15:0] rd;
    run_burst(8, 1'b0);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after burst", rd, 16'h0004);
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT after burst", rd, 16'd8);
endtask

task automatic apply_backpressure();
    logic [15:0] rd;
    run_burst(12, 1'b1);
    // Done set and overflow clear
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after stalled burst", rd, 16'h0004);
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT after stalled burst", rd, 16'd12);
endtask

task automatic overflow_fifo();
    logic [15:0] rd;
    @(negedge clk_sys_i);
    rx_ready_i = 1'b0;
    write_reg(hyper_rx_pkg::BURST_LEN, 16'd20);
    write_reg(hyper_rx_pkg::CTRL, 16'h0001);
    prepare_words(20);
    drive_burst();
    wait_status(16'h0002, 16'h0002, "overflow to set");
    // First 16 words are kept and the last 4 are lost
    collect_words(16, 1'b0);
    exp_q.delete();
    expect_idle(8);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after overflow", rd, 16'h0003);
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT after overflow", rd, 16'd16);
    write_reg(hyper_rx_pkg::CTRL, 16'h0000);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after abort", rd, 16'h0002);
endtask

task automatic clear_sticky_flags();
    logic [15:0] rd;
    // Zero bits leave the flags alone
    write_reg(hyper_rx_pkg::STATUS, 16'h0000);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after zero write", rd, 16'h0002);
    write_reg(hyper_rx_pkg::STATUS, 16'h0002);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after overflow clear", rd, 16'h0000);
    run_burst(4, 1'b0);
    write_reg(hyper_rx_pkg::STATUS, 16'h0004);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after done clear", rd, 16'h0000);
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT kept", rd, 16'd4);
    // Fresh burst counts from zero
    write_reg(hyper_rx_pkg::BURST_LEN, 16'd6);
    write_reg(hyper_rx_pkg::CTRL, 16'h0001);
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT after re-arm", rd, 16'd0);
    stream_burst(6, 1'b0);
    read_reg(hyper_rx_pkg::STATUS, rd);
    check_value("STATUS after fresh burst", rd, 16'h0004);
    read_reg(hyper_rx_pkg::COUNT, rd);
    check_value("COUNT after fresh burst", rd, 16'd6);
endtask

//--- verif/hyper_rx_tb.sv
// Testbench top for the HyperBus receive path: clock, reset, DUT, LFSR, register access, report

`default_nettype none

`include "hyper_rx_params.svh"

module hyper_rx_tb;

    localparam int CLK_PERIOD = 100;
    // RWDS period is 60, DQ moves a quarter period before each edge
    localparam int RWDS_QUARTER = 15;
    // Register reads sampled between the falling and the rising edge
    localparam int READ_SETTLE = 25;
    localparam int WORD_TIMEOUT = 400;
    localparam int STATUS_TIMEOUT = 100;

    logic                        clk_sys_i;
    logic                        rst_ni;
    logic                        hyper_rwds_i;
    logic [7:0]                  hyper_dq_i;
    logic                        cfg_we_i;
    hyper_rx_pkg::reg_addr_e     cfg_addr_i;
    logic [`HYPER_RX_WORD_W-1:0] cfg_wdata_i;
    logic [`HYPER_RX_WORD_W-1:0] cfg_rdata_o;
    hyper_rx_pkg::hyper_word_t   rx_data_o;
    logic                        rx_valid_o;
    logic                        rx_ready_i;

    // Words still due on the stream, and words still to put on DQ
    hyper_rx_pkg::hyper_word_t exp_q[$];
    hyper_rx_pkg::hyper_word_t send_q[$];

    int unsigned err_count;
    int unsigned timeout_count;
    logic [31:0] lfsr_state;

    hyper_rx_top dut_i (
        .clk_sys_i    ( clk_sys_i    ),
        .rst_ni       ( rst_ni       ),
        .hyper_rwds_i ( hyper_rwds_i ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .cfg_we_i     ( cfg_we_i     ),
        .cfg_addr_i   ( cfg_addr_i   ),
        .cfg_wdata_i  ( cfg_wdata_i  ),
        .cfg_rdata_o  ( cfg_rdata_o  ),
        .rx_data_o    ( rx_data_o    ),
        .rx_valid_o   ( rx_valid_o   ),
        .rx_ready_i   ( rx_ready_i   )
    );

    initial begin
        clk_sys_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys_i = ~clk_sys_i;
    end

    // Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One step per bit taken
    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        int i;
        for (i = 0; i < 8; i++) begin
            b[i] = rand_bit();
        end
        return b;
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp) else begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timed out at time %0t waiting for %s", $time, what);
        timeout_count++;
    endtask

    // Write lands on the rising edge between the two falling edges
    task automatic write_reg(input hyper_rx_pkg::reg_addr_e addr, input logic [15:0] data);
        @(negedge clk_sys_i);
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_wdata_i = data;
        @(negedge clk_sys_i);
        cfg_we_i = 1'b0;
    endtask

    // Read data is combinational from the address
    task automatic read_reg(input hyper_rx_pkg::reg_addr_e addr, output logic [15:0] data);
        @(negedge clk_sys_i);
        cfg_addr_i = addr;
        #READ_SETTLE;
        data = cfg_rdata_o;
    endtask

    `include "hyper_rx_tests.svh"

    initial begin
        err_count = 0;
        timeout_count = 0;
        lfsr_state = 32'd84946;
        rst_ni = 1'b0;
        hyper_rwds_i = 1'b0;
        hyper_dq_i = 8'h00;
        cfg_we_i = 1'b0;
        cfg_addr_i = hyper_rx_pkg::CTRL;
        cfg_wdata_i = '0;
        rx_ready_i = 1'b0;
        repeat (16) @(negedge clk_sys_i);
        rst_ni = 1'b1;
        access_registers();
        run_basic_burst();
        apply_backpressure();
        overflow_fifo();
        clear_sticky_flags();
        $display("Failed checks: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
